/* bpu_cfg.svh */
`ifndef BPU_CFG_SVH
`define BPU_CFG_SVH

`define BPU_PC_W     32                              // fetch address width
`define BPU_INDEX_W  8                               // table index bits
`define BPU_DEPTH    256                             // entries, 2**index width
`define BPU_IDX_LSB  2                               // pcs are word aligned

// tag covers everything above the index field
`define BPU_TAG_LSB  (`BPU_IDX_LSB + `BPU_INDEX_W)
`define BPU_TAG_W    (`BPU_PC_W - `BPU_INDEX_W - `BPU_IDX_LSB)

`endif

/* bpu_pkg.sv */
`include "bpu_cfg.svh"

package bpu_pkg;

    // 2-bit saturating counter, bit 1 clear means predict taken
    typedef enum logic [1:0] {
        cnt_w_taken  = 2'b00,                        // weak taken
        cnt_s_taken  = 2'b01,                        // strong taken
        cnt_wn_taken = 2'b10,                        // weak not-taken
        cnt_sn_taken = 2'b11                         // strong not-taken
    } bpu_cnt_e;

    // one table entry, 56 bits
    typedef struct packed {
        bpu_cnt_e              count;
        logic [`BPU_TAG_W-1:0] tag;
        logic [`BPU_PC_W-1:0]  target;
    } pht_entry_t;

    // resolved branch from execute, 68 bits
    typedef struct packed {
        logic [`BPU_PC_W-1:0] pc;                    // pc of the branch
        bpu_cnt_e             old_count;             // count seen at predict time
        logic                 is_branch;             // one-cycle strobe
        logic                 taken;                 // actual outcome
        logic [`BPU_PC_W-1:0] target;                // actual branch target
    } bresult_t;

    // prediction bundle handed to decode, 36 bits
    typedef struct packed {
        logic                 taken;
        bpu_cnt_e             count;
        logic                 valid;
        logic [`BPU_PC_W-1:0] ret_addr;              // predicted next fetch address
    } pred_bus_t;

endpackage

/* pht_ram.sv */
`timescale 1ns/1ps

module pht_ram #(
    parameter int DEPTH = 256,
    parameter int WIDTH = 56
) (
    input  logic                     clk,
    input  logic                     wr_en,
    input  logic [$clog2(DEPTH)-1:0] wr_addr,
    input  logic [WIDTH-1:0]         wr_data,
    input  logic                     rd_en,
    input  logic [$clog2(DEPTH)-1:0] rd_addr,
    output logic [WIDTH-1:0]         rd_data
);

    logic [WIDTH-1:0] mem [DEPTH];

    // write port
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // registered read, holds while rd_en is low
    // same-address read and write returns the old word
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

/* pht_table.sv */
`timescale 1ns/1ps
`include "bpu_cfg.svh"

module pht_table (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       wr_en,
    input  logic [`BPU_INDEX_W-1:0]    wr_index,
    input  bpu_pkg::pht_entry_t        wr_entry,
    input  logic                       rd_en,
    input  logic [`BPU_INDEX_W-1:0]    rd_index,
    output bpu_pkg::pht_entry_t        rd_entry,
    output logic                       rd_entry_valid,
    output logic                       rd_collide
);

    import bpu_pkg::*;

    logic [`BPU_DEPTH-1:0] entry_valid;              // one flag per entry

    pht_ram #(
        .DEPTH (`BPU_DEPTH),
        .WIDTH ($bits(pht_entry_t))
    ) u_ram (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_index),
        .wr_data (wr_entry),
        .rd_en   (rd_en),
        .rd_addr (rd_index),
        .rd_data (rd_entry)
    );

    // valid flags, cleared on reset and set by any write
    always_ff @(posedge clk) begin
        if (reset) begin
            entry_valid <= '0;
        end else if (wr_en) begin
            entry_valid[wr_index] <= 1'b1;
        end
    end

    // read the flag in step with the storage read
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_entry_valid <= 1'b0;
        end else if (rd_en) begin
            rd_entry_valid <= entry_valid[rd_index];   // pre-write value
        end
    end

    // a read racing a write may see stale data, so flag it
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_collide <= 1'b0;
        end else begin
            rd_collide <= rd_en & wr_en;
        end
    end

endmodule

/* counter_update.sv */
`timescale 1ns/1ps
`include "bpu_cfg.svh"

module counter_update (
    input  logic                       clk,
    input  logic                       reset,
    input  bpu_pkg::bresult_t          bresult,
    output logic                       wr_en,
    output logic [`BPU_INDEX_W-1:0]    wr_index,
    output bpu_pkg::pht_entry_t        wr_entry
);

    import bpu_pkg::*;

    bresult_t rec_q;                                 // last resolved branch
    bpu_cnt_e new_count;

    // strobe stage, one write per resolved branch
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_en <= 1'b0;
        end else begin
            wr_en <= bresult.is_branch;
        end
    end

    // payload only captured with the strobe
    always_ff @(posedge clk) begin
        if (bresult.is_branch) begin
            rec_q <= bresult;
        end
    end

    // saturating step, strong taken now saturates on taken
    always_comb begin
        case (rec_q.old_count)
            cnt_sn_taken: new_count = rec_q.taken ? cnt_wn_taken : cnt_sn_taken;
            cnt_wn_taken: new_count = rec_q.taken ? cnt_w_taken  : cnt_sn_taken;
            cnt_w_taken:  new_count = rec_q.taken ? cnt_s_taken  : cnt_wn_taken;
            cnt_s_taken:  new_count = rec_q.taken ? cnt_s_taken  : cnt_w_taken;
            default:      new_count = cnt_w_taken;
        endcase
    end

    assign wr_index        = rec_q.pc[`BPU_TAG_LSB-1:`BPU_IDX_LSB];
    assign wr_entry.count  = new_count;
    assign wr_entry.tag    = rec_q.pc[`BPU_PC_W-1:`BPU_TAG_LSB];
    assign wr_entry.target = rec_q.target;           // stored even if not taken

endmodule

/* predict_stage.sv */
`timescale 1ns/1ps
`include "bpu_cfg.svh"

module predict_stage (
    input  logic                       clk,
    input  logic                       reset,
    input  logic [`BPU_PC_W-1:0]       lookup_pc,
    input  logic                       lookup_valid,
    input  logic                       ds_allowin,
    input  bpu_pkg::pht_entry_t        rd_entry,
    input  logic                       rd_entry_valid,
    input  logic                       rd_collide,
    output logic                       rd_en,
    output logic [`BPU_INDEX_W-1:0]    rd_index,
    output logic                       hit,
    output logic [`BPU_PC_W-1:0]       target,
    output bpu_pkg::pred_bus_t         ds_bus
);

    import bpu_pkg::*;

    logic [`BPU_PC_W-1:0] pc_q;                      // pc of the lookup in flight
    logic                 lookup_valid_q;
    logic                 tag_match;
    pred_bus_t            ds_next;

    // table read issued straight from fetch
    assign rd_en    = lookup_valid;
    assign rd_index = lookup_pc[`BPU_TAG_LSB-1:`BPU_IDX_LSB];

    // align pc and valid with the table output
    always_ff @(posedge clk) begin
        if (reset) begin
            lookup_valid_q <= 1'b0;
        end else begin
            lookup_valid_q <= lookup_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (lookup_valid) begin
            pc_q <= lookup_pc;
        end
    end

    assign tag_match = (rd_entry.tag == pc_q[`BPU_PC_W-1:`BPU_TAG_LSB]);
    assign hit       = lookup_valid_q & rd_entry_valid & tag_match & ~rd_collide;

    // not-taken counters fall through to the sequential pc
    assign target = rd_entry.count[1] ? pc_q + `BPU_PC_W'(4) : rd_entry.target;

    // bundle contents, all zero on a miss
    always_comb begin
        ds_next = '0;
        if (hit) begin
            ds_next.valid    = 1'b1;
            ds_next.count    = rd_entry.count;
            ds_next.taken    = ~rd_entry.count[1];
            ds_next.ret_addr = target;
        end
    end

    // decode bundle, held while decode is stalled
    always_ff @(posedge clk) begin
        if (reset) begin
            ds_bus <= '0;
        end else if (ds_allowin) begin
            ds_bus <= ds_next;
        end
    end

endmodule

/* bpu.sv */
`timescale 1ns/1ps
`include "bpu_cfg.svh"

module bpu (
    input  logic                       clk,
    input  logic                       reset,
    input  logic [`BPU_PC_W-1:0]       lookup_pc,
    input  logic                       lookup_valid,
    input  bpu_pkg::bresult_t          bresult,
    input  logic                       ds_allowin,
    output logic                       hit,
    output logic [`BPU_PC_W-1:0]       target,
    output bpu_pkg::pred_bus_t         ds_bus
);

    import bpu_pkg::*;

    // update path into the table
    logic                    wr_en;
    logic [`BPU_INDEX_W-1:0] wr_index;
    pht_entry_t              wr_entry;

    // lookup path
    logic                    rd_en;
    logic [`BPU_INDEX_W-1:0] rd_index;
    pht_entry_t              rd_entry;
    logic                    rd_entry_valid;
    logic                    rd_collide;

    counter_update u_update (
        .clk      (clk),
        .reset    (reset),
        .bresult  (bresult),
        .wr_en    (wr_en),
        .wr_index (wr_index),
        .wr_entry (wr_entry)
    );

    pht_table u_table (
        .clk            (clk),
        .reset          (reset),
        .wr_en          (wr_en),
        .wr_index       (wr_index),
        .wr_entry       (wr_entry),
        .rd_en          (rd_en),
        .rd_index       (rd_index),
        .rd_entry       (rd_entry),
        .rd_entry_valid (rd_entry_valid),
        .rd_collide     (rd_collide)
    );

    predict_stage u_predict (
        .clk            (clk),
        .reset          (reset),
        .lookup_pc      (lookup_pc),
        .lookup_valid   (lookup_valid),
        .ds_allowin     (ds_allowin),
        .rd_entry       (rd_entry),
        .rd_entry_valid (rd_entry_valid),
        .rd_collide     (rd_collide),
        .rd_en          (rd_en),
        .rd_index       (rd_index),
        .hit            (hit),
        .target         (target),
        .ds_bus         (ds_bus)
    );

endmodule

/* tb_bpu.sv */
`timescale 1ns/1ps
`include "bpu_cfg.svh"

module tb_bpu;

    import bpu_pkg::*;

    localparam int CLK_HALF    = 20;                 // 40 ns period
    localparam int RUN_LIMIT   = 5000;               // cycles before the run counts as hung
    localparam int RESET_LIMIT = 50;
    localparam int RAND_CYCLES = 400;

    logic                  clk;
    logic                  reset;
    logic [`BPU_PC_W-1:0]  lookup_pc;
    logic                  lookup_valid;
    bresult_t              bresult;
    logic                  ds_allowin;
    logic                  hit;
    logic [`BPU_PC_W-1:0]  target;
    pred_bus_t             ds_bus;

    // reference copy of the table
    logic [`BPU_DEPTH-1:0] m_valid;
    logic [`BPU_TAG_W-1:0] m_tag [`BPU_DEPTH];
    bpu_cnt_e              m_count [`BPU_DEPTH];
    logic [`BPU_PC_W-1:0]  m_target [`BPU_DEPTH];

    logic                  pend_valid;               // record waiting for its table write
    bresult_t              pend_rec;
    pred_bus_t             exp_pred;                 // expected result of the lookup in flight
    pred_bus_t             exp_ds;

    logic [`BPU_PC_W-1:0]  pc_set [12];
    logic [31:0]           rng_state = 32'd10;
    logic                  stim_done = 1'b0;
    string                 test_name;

    bpu uut (
        .clk          (clk),
        .reset        (reset),
        .lookup_pc    (lookup_pc),
        .lookup_valid (lookup_valid),
        .bresult      (bresult),
        .ds_allowin   (ds_allowin),
        .hit          (hit),
        .target       (target),
        .ds_bus       (ds_bus)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic next_rand(output logic [31:0] r);
        rng_state = xorshift32(rng_state);
        r = rng_state;
    endtask

    // 2-bit saturating step, strong taken holds on taken
    function automatic bpu_cnt_e next_count(input bpu_cnt_e old, input logic taken);
        bpu_cnt_e n;
        case (old)
            cnt_sn_taken: n = taken ? cnt_wn_taken : cnt_sn_taken;
            cnt_wn_taken: n = taken ? cnt_w_taken  : cnt_sn_taken;
            cnt_w_taken:  n = taken ? cnt_s_taken  : cnt_wn_taken;
            default:      n = taken ? cnt_s_taken  : cnt_w_taken;
        endcase
        return n;
    endfunction

    // expected prediction for a lookup, zero bundle on a miss
    function automatic pred_bus_t predict_ref(input logic [`BPU_PC_W-1:0] pc,
                                              input logic collide);
        pred_bus_t                p;
        logic [`BPU_INDEX_W-1:0]  idx;
        bpu_cnt_e                 cnt;
        idx = pc[`BPU_TAG_LSB-1:`BPU_IDX_LSB];
        cnt = m_count[idx];
        p   = '0;
        if (!collide && m_valid[idx] && m_tag[idx] == pc[`BPU_PC_W-1:`BPU_TAG_LSB]) begin
            p.valid    = 1'b1;
            p.count    = cnt;
            p.taken    = ~cnt[1];
            p.ret_addr = cnt[1] ? pc + 32'd4 : m_target[idx];
        end
        return p;
    endfunction

    // count that execute would hold for this pc, pending write included
    function automatic bpu_cnt_e current_count(input logic [`BPU_PC_W-1:0] pc);
        logic [`BPU_INDEX_W-1:0] idx;
        bpu_cnt_e                c;
        idx = pc[`BPU_TAG_LSB-1:`BPU_IDX_LSB];
        c   = cnt_w_taken;
        if (pend_valid && pend_rec.pc[`BPU_TAG_LSB-1:`BPU_IDX_LSB] == idx) begin
            if (pend_rec.pc[`BPU_PC_W-1:`BPU_TAG_LSB] == pc[`BPU_PC_W-1:`BPU_TAG_LSB]) begin
                c = next_count(pend_rec.old_count, pend_rec.taken);
            end
        end else if (m_valid[idx] && m_tag[idx] == pc[`BPU_PC_W-1:`BPU_TAG_LSB]) begin
            c = m_count[idx];
        end
        return c;
    endfunction

    // one clock edge of the reference model
    task automatic model_edge();
        logic [`BPU_INDEX_W-1:0] widx;
        if (reset) begin
            m_valid    = '0;
            pend_valid = 1'b0;
            exp_pred   = '0;
            exp_ds     = '0;
        end else begin
            if (ds_allowin) begin
                exp_ds = exp_pred;                   // bundle of the result on show
            end
            if (lookup_valid) begin
                exp_pred = predict_ref(lookup_pc, pend_valid);
            end else begin
                exp_pred = '0;
            end
            if (pend_valid) begin
                widx           = pend_rec.pc[`BPU_TAG_LSB-1:`BPU_IDX_LSB];
                m_valid[widx]  = 1'b1;
                m_tag[widx]    = pend_rec.pc[`BPU_PC_W-1:`BPU_TAG_LSB];
                m_count[widx]  = next_count(pend_rec.old_count, pend_rec.taken);
                m_target[widx] = pend_rec.target;
            end
            pend_valid = bresult.is_branch;
            if (bresult.is_branch) begin
                pend_rec = bresult;
            end
        end
    endtask

    always @(posedge clk) model_edge();

    task automatic abort_run(input string msg);
        $display("TEST FAILED");
        $fatal(1, "%s", msg);
    endtask

    task automatic check_outputs();
        assert (hit === exp_pred.valid) else begin
            $display("Mismatch %s: hit expected %0b actual %0b", test_name, exp_pred.valid, hit);
            abort_run("hit differs from the reference model");
        end
        if (exp_pred.valid) begin
            assert (target === exp_pred.ret_addr) else begin
                $display("Mismatch %s: target expected %h actual %h",
                         test_name, exp_pred.ret_addr, target);
                abort_run("predicted target differs from the reference model");
            end
        end
        assert (ds_bus === exp_ds) else begin
            $display("Mismatch %s: ds_bus expected %h actual %h", test_name, exp_ds, ds_bus);
            abort_run("decode bundle differs from the reference model");
        end
    endtask

    // comparing process, outputs are settled by the falling edge
    initial begin
        int waited;
        waited = 0;
        while (reset !== 1'b0 && waited < RESET_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (reset !== 1'b0) begin
            $display("TEST FAILED");
            $fatal(1, "reset was never released");
        end else begin
            forever begin
                @(negedge clk);
                check_outputs();
            end
        end
    end

    // one cycle of inputs, applied on the falling edge
    task automatic drive_cycle(input logic lv, input logic [`BPU_PC_W-1:0] lpc,
                               input logic br, input logic [`BPU_PC_W-1:0] bpc,
                               input logic tk, input logic [`BPU_PC_W-1:0] tgt,
                               input logic allow);
        @(negedge clk);
        lookup_valid       = lv;
        lookup_pc          = lpc;
        ds_allowin         = allow;
        bresult.pc         = bpc;
        bresult.old_count  = br ? current_count(bpc) : cnt_w_taken;
        bresult.is_branch  = br;
        bresult.taken      = tk;
        bresult.target     = tgt;
    endtask

    task automatic idle_cycle();
        drive_cycle(1'b0, '0, 1'b0, '0, 1'b0, '0, 1'b1);
    endtask

    // direct check of the bundle against values from the counter rules
    task automatic check_bundle(input logic v, input bpu_cnt_e c, input logic tk,
                                input logic [`BPU_PC_W-1:0] ra);
        pred_bus_t e;
        e.valid    = v;
        e.count    = c;
        e.taken    = tk;
        e.ret_addr = ra;
        assert (ds_bus === e) else begin
            $display("Mismatch %s: ds_bus expected %h actual %h", test_name, e, ds_bus);
            abort_run("decode bundle differs from the expected value");
        end
    endtask

    // lookup, then wait until its bundle is in ds_bus
    task automatic probe(input logic [`BPU_PC_W-1:0] pc);
        drive_cycle(1'b1, pc, 1'b0, '0, 1'b0, '0, 1'b1);
        idle_cycle();
        idle_cycle();
    endtask

    task automatic resolve_and_probe(input logic [`BPU_PC_W-1:0] pc, input logic tk,
                                     input logic [`BPU_PC_W-1:0] tgt, input bpu_cnt_e c,
                                     input logic exp_tk, input logic [`BPU_PC_W-1:0] ra);
        drive_cycle(1'b0, '0, 1'b1, pc, tk, tgt, 1'b1);
        idle_cycle();                                // table write lands here
        probe(pc);
        check_bundle(1'b1, c, exp_tk, ra);
    endtask

    task automatic run_random(input int cycles);
        logic [31:0]          r;
        logic [3:0]           lk;
        logic [3:0]           bk;
        logic [`BPU_PC_W-1:0] tgt;
        for (int n = 0; n < cycles; n++) begin
            next_rand(r);
            lk  = r[7:4] % 4'd12;
            bk  = r[15:12] % 4'd12;
            tgt = {16'h0, r[31:18], 2'b00};
            drive_cycle(r[0] | r[1], pc_set[lk], r[8], pc_set[bk], r[16], tgt,
                        r[17] | r[10] | r[11]);
        end
    endtask

    initial begin
        logic [3:0] k;
        reset        = 1'b1;
        lookup_valid = 1'b0;
        lookup_pc    = '0;
        bresult      = '0;
        ds_allowin   = 1'b1;
        test_name    = "reset";
        pc_set[0]    = 32'h0000_0054;                // index 0x15, four tags
        pc_set[1]    = 32'h0000_0454;
        pc_set[2]    = 32'h0001_0054;
        pc_set[3]    = 32'h8000_0054;
        pc_set[4]    = 32'h0000_1000;
        pc_set[5]    = 32'h0000_1004;
        pc_set[6]    = 32'h0000_2108;
        pc_set[7]    = 32'h0040_03fc;
        pc_set[8]    = 32'h1234_5678;
        pc_set[9]    = 32'h0000_0100;
        pc_set[10]   = 32'hffff_fff0;
        pc_set[11]   = 32'h0bad_0f0c;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        test_name = "after_reset";
        for (k = 4'd0; k < 4'd6; k++) begin
            drive_cycle(1'b1, pc_set[k], 1'b0, '0, 1'b0, '0, 1'b1);
        end
        idle_cycle();
        idle_cycle();
        check_bundle(1'b0, cnt_w_taken, 1'b0, '0);

        test_name = "install";
        resolve_and_probe(pc_set[0], 1'b1, 32'h0000_8000, cnt_s_taken, 1'b1, 32'h0000_8000);

        test_name = "counter_walk";
        resolve_and_probe(pc_set[4], 1'b0, 32'h0000_3000, cnt_wn_taken, 1'b0, 32'h0000_1004);
        resolve_and_probe(pc_set[4], 1'b0, 32'h0000_3000, cnt_sn_taken, 1'b0, 32'h0000_1004);
        resolve_and_probe(pc_set[4], 1'b0, 32'h0000_3000, cnt_sn_taken, 1'b0, 32'h0000_1004);
        resolve_and_probe(pc_set[4], 1'b1, 32'h0000_3000, cnt_wn_taken, 1'b0, 32'h0000_1004);
        resolve_and_probe(pc_set[4], 1'b1, 32'h0000_3000, cnt_w_taken,  1'b1, 32'h0000_3000);
        resolve_and_probe(pc_set[4], 1'b1, 32'h0000_3000, cnt_s_taken,  1'b1, 32'h0000_3000);
        resolve_and_probe(pc_set[4], 1'b1, 32'h0000_3000, cnt_s_taken,  1'b1, 32'h0000_3000);
        resolve_and_probe(pc_set[4], 1'b0, 32'h0000_3000, cnt_w_taken,  1'b1, 32'h0000_3000);

        test_name = "aliasing";
        probe(pc_set[1]);
        check_bundle(1'b0, cnt_w_taken, 1'b0, '0);
        resolve_and_probe(pc_set[1], 1'b1, 32'h0000_9000, cnt_s_taken, 1'b1, 32'h0000_9000);
        probe(pc_set[0]);                            // evicted by the alias
        check_bundle(1'b0, cnt_w_taken, 1'b0, '0);

        test_name = "collision";
        drive_cycle(1'b0, '0, 1'b1, pc_set[1], 1'b1, 32'h0000_9000, 1'b1);
        drive_cycle(1'b1, pc_set[1], 1'b0, '0, 1'b0, '0, 1'b1);
        idle_cycle();
        idle_cycle();
        check_bundle(1'b0, cnt_w_taken, 1'b0, '0);
        probe(pc_set[1]);
        check_bundle(1'b1, cnt_s_taken, 1'b1, 32'h0000_9000);

        test_name = "back_pressure";
        drive_cycle(1'b1, pc_set[4], 1'b0, '0, 1'b0, '0, 1'b1);
        drive_cycle(1'b1, pc_set[5], 1'b0, '0, 1'b0, '0, 1'b1);
        for (k = 4'd5; k < 4'd12; k++) begin
            drive_cycle(1'b1, pc_set[k], 1'b0, '0, 1'b0, '0, 1'b0);
        end
        drive_cycle(1'b1, pc_set[1], 1'b0, '0, 1'b0, '0, 1'b0);
        check_bundle(1'b1, cnt_w_taken, 1'b1, 32'h0000_3000);
        idle_cycle();                                // allow-in back high
        idle_cycle();
        check_bundle(1'b1, cnt_s_taken, 1'b1, 32'h0000_9000);

        test_name = "random";
        run_random(RAND_CYCLES);
        repeat (4) idle_cycle();
        stim_done = 1'b1;
    end

    // end of run, guarded against a stuck stimulus
    initial begin
        int cycles;
        cycles = 0;
        while (!stim_done && cycles < RUN_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (stim_done) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            $display("TEST FAILED");
            $fatal(1, "stimulus did not finish within the cycle limit");
        end
    end

endmodule

/* bpu.f */
+incdir+.
bpu_pkg.sv
pht_ram.sv
pht_table.sv
counter_update.sv
predict_stage.sv
bpu.sv
tb_bpu.sv

/* run_sim.sh */
#!/usr/bin/env bash
# compile and run the bpu testbench with Verilator
# exit status is nonzero when the testbench stops with $fatal
set -e

cd "$(dirname "$0")"

rm -rf obj_dir

verilator --binary --timing --assert \
    -f bpu.f \
    --top-module tb_bpu \
    -o sim_bpu

./obj_dir/sim_bpu
